// File: hdl/cpu_consts.svh
// ######################################
// core constants: widths, reset PC and
// RV32I opcode and funct encodings
// ######################################
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN         32
`define CPU_REG_AW       5
`define CPU_RESET_PC     32'h0000_0000
`define CPU_FETCH_BYTES  4
`define CPU_LAMP_N       4

// major opcodes kept by this core
`define CPU_OPC_OP       7'b0110011
`define CPU_OPC_OP_IMM   7'b0010011
`define CPU_OPC_LUI      7'b0110111

// funct3 values shared by OP and OP-IMM
`define CPU_F3_ADD       3'b000
`define CPU_F3_SLL       3'b001
`define CPU_F3_SLT       3'b010
`define CPU_F3_SLTU      3'b011
`define CPU_F3_XOR       3'b100
`define CPU_F3_SR        3'b101
`define CPU_F3_OR        3'b110
`define CPU_F3_AND       3'b111

// bit of funct7 that selects SUB and SRA
`define CPU_F7_ALT_BIT   5

`endif

// File: hdl/cpu_pkg.sv
// ######################################
// shared types of the RV32I subset core
// ######################################
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0]   word_t;
  typedef logic [`CPU_XLEN-1:0]   addr_t;
  typedef logic [`CPU_XLEN-1:0]   instr_t;
  typedef logic [`CPU_REG_AW-1:0] reg_addr_t;
  typedef logic [7:0]             byte_t;
  typedef logic [`CPU_LAMP_N-1:0] lamp_t;

  // ALU_PASS forwards rhs, used for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS
  } alu_op_t;

  // byte fetch sequencing
  typedef enum logic [1:0] {
    FETCH_ADDR,
    FETCH_LAST,
    FETCH_DONE
  } fetch_state_t;

endpackage

// File: hdl/exec_if.sv
// ######################################
// one issued ALU operation, decode to ALU
// ######################################
`timescale 1ns/1ps

interface exec_if;

  logic                 issue_valid;
  cpu_pkg::alu_op_t     alu_op;
  cpu_pkg::word_t       lhs;
  cpu_pkg::word_t       rhs;
  cpu_pkg::reg_addr_t   rd;

  modport decode (
    output issue_valid,
    output alu_op,
    output lhs,
    output rhs,
    output rd
  );

  modport alu (
    input issue_valid,
    input alu_op,
    input lhs,
    input rhs,
    input rd
  );

endinterface

// File: hdl/byte_fetcher.sv
// ######################################
// byte-serial instruction fetch with PC
// ######################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module byte_fetcher (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  cpu_pkg::byte_t  mem_din,
  output cpu_pkg::addr_t  mem_a,
  output logic            instr_valid,
  output cpu_pkg::instr_t instr,
  output logic            fetch_start
);

  cpu_pkg::fetch_state_t                 state_q;
  logic [$clog2(`CPU_FETCH_BYTES)-1:0]   cnt_q;
  logic [$clog2(`CPU_FETCH_BYTES)-1:0]   cap_idx;
  cpu_pkg::addr_t                        pc_q;
  cpu_pkg::instr_t                       instr_q;
  logic                                  stale_q;
  logic                                  capture_en;

  // byte cnt_q of the current word is on the bus this cycle
  assign mem_a = pc_q + cpu_pkg::addr_t'(cnt_q);

  // data lags the address by one cycle, except in FETCH_LAST
  // where pc+3 is still presented
  assign cap_idx = (state_q == cpu_pkg::FETCH_LAST) ? cnt_q : cnt_q - 1'b1;

  // after a pause the bus holds the byte of the paused address,
  // which is only the wanted one in FETCH_LAST
  assign capture_en = rdy_in &&
                      ((state_q == cpu_pkg::FETCH_ADDR && cnt_q != '0 && !stale_q) ||
                       state_q == cpu_pkg::FETCH_LAST);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= cpu_pkg::FETCH_ADDR;
      cnt_q   <= '0;
      pc_q    <= `CPU_RESET_PC;
      stale_q <= 1'b0;
    end else if (!rdy_in) begin
      stale_q <= 1'b1;
    end else begin
      stale_q <= 1'b0;
      case (state_q)
        cpu_pkg::FETCH_ADDR: begin
          if (stale_q && cnt_q != '0) begin
            // previous byte was lost in the pause, refetch the word
            cnt_q <= '0;
          end else if (int'(cnt_q) == `CPU_FETCH_BYTES - 1) begin
            state_q <= cpu_pkg::FETCH_LAST;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        cpu_pkg::FETCH_LAST: begin
          pc_q    <= pc_q + cpu_pkg::addr_t'(`CPU_FETCH_BYTES);
          cnt_q   <= '0;
          state_q <= cpu_pkg::FETCH_DONE;
        end
        cpu_pkg::FETCH_DONE: begin
          // next word's first address went out this cycle
          cnt_q   <= cnt_q + 1'b1;
          state_q <= cpu_pkg::FETCH_ADDR;
        end
        default: begin
          state_q <= cpu_pkg::FETCH_ADDR;
        end
      endcase
    end
  end

  // little-endian assembly of the word
  always_ff @(posedge clk_in) begin
    if (capture_en) begin
      instr_q[8*cap_idx +: 8] <= mem_din;
    end
  end

  assign instr       = instr_q;
  assign instr_valid = rdy_in && state_q == cpu_pkg::FETCH_DONE;
  assign fetch_start = rdy_in && state_q != cpu_pkg::FETCH_LAST && cnt_q == '0;

endmodule

// File: hdl/decode_issue.sv
// ######################################
// decode, register file and issue to ALU
// ######################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_issue (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rdy_in,
  input  logic               instr_valid,
  input  cpu_pkg::instr_t    instr,
  input  logic               retire_valid,
  input  cpu_pkg::reg_addr_t retire_rd,
  input  cpu_pkg::word_t     retire_value,
  exec_if.decode             exec
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                alt_bit;
  logic                is_shift;
  cpu_pkg::reg_addr_t  rd;
  cpu_pkg::reg_addr_t  rs1;
  cpu_pkg::reg_addr_t  rs2;
  cpu_pkg::word_t      imm_i;
  cpu_pkg::word_t      imm_u;
  cpu_pkg::word_t      shamt;
  cpu_pkg::word_t      rs1_val;
  cpu_pkg::word_t      rs2_val;

  logic                supported;
  cpu_pkg::alu_op_t    op_sel;
  cpu_pkg::word_t      lhs_sel;
  cpu_pkg::word_t      rhs_sel;

  logic                issue_q;
  cpu_pkg::alu_op_t    op_q;
  cpu_pkg::word_t      lhs_q;
  cpu_pkg::word_t      rhs_q;
  cpu_pkg::reg_addr_t  rd_q;

  // x1..x31, x0 is hardwired
  cpu_pkg::word_t      regs_q [1:(1 << `CPU_REG_AW) - 1];

  function automatic cpu_pkg::alu_op_t funct_to_op(input logic [2:0] f3, input logic alt);
    cpu_pkg::alu_op_t op;
    case (f3)
      `CPU_F3_ADD:  op = alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
      `CPU_F3_SLL:  op = cpu_pkg::ALU_SLL;
      `CPU_F3_SLT:  op = cpu_pkg::ALU_SLT;
      `CPU_F3_SLTU: op = cpu_pkg::ALU_SLTU;
      `CPU_F3_XOR:  op = cpu_pkg::ALU_XOR;
      `CPU_F3_SR:   op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
      `CPU_F3_OR:   op = cpu_pkg::ALU_OR;
      `CPU_F3_AND:  op = cpu_pkg::ALU_AND;
      default:      op = cpu_pkg::ALU_ADD;
    endcase
    return op;
  endfunction

  // instruction fields
  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign alt_bit  = instr[25 + `CPU_F7_ALT_BIT];
  assign imm_i    = {{20{instr[31]}}, instr[31:20]};
  assign imm_u    = {instr[31:12], 12'b0};
  assign shamt    = cpu_pkg::word_t'(instr[24:20]);
  assign is_shift = funct3 == `CPU_F3_SLL || funct3 == `CPU_F3_SR;

  assign rs1_val = (rs1 == '0) ? '0 : regs_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs_q[rs2];

  always_comb begin
    supported = 1'b0;
    op_sel    = cpu_pkg::ALU_ADD;
    lhs_sel   = rs1_val;
    rhs_sel   = rs2_val;
    case (opcode)
      `CPU_OPC_OP: begin
        supported = 1'b1;
        op_sel    = funct_to_op(funct3, alt_bit);
      end
      `CPU_OPC_OP_IMM: begin
        supported = 1'b1;
        // no SUBI, the alt bit only turns SRLI into SRAI
        op_sel    = funct_to_op(funct3, alt_bit && funct3 == `CPU_F3_SR);
        rhs_sel   = is_shift ? shamt : imm_i;
      end
      `CPU_OPC_LUI: begin
        supported = 1'b1;
        op_sel    = cpu_pkg::ALU_PASS;
        lhs_sel   = '0;
        rhs_sel   = imm_u;
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      issue_q <= 1'b0;
    end else if (rdy_in) begin
      issue_q <= instr_valid && supported;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && instr_valid) begin
      op_q  <= op_sel;
      lhs_q <= lhs_sel;
      rhs_q <= rhs_sel;
      rd_q  <= rd;
    end
  end

  // architectural registers start at zero
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 1; i < (1 << `CPU_REG_AW); i++) begin
        regs_q[i] <= '0;
      end
    end else if (retire_valid && retire_rd != '0) begin
      regs_q[retire_rd] <= retire_value;
    end
  end

  assign exec.issue_valid = issue_q && rdy_in;
  assign exec.alu_op      = op_q;
  assign exec.lhs         = lhs_q;
  assign exec.rhs         = rhs_q;
  assign exec.rd          = rd_q;

endmodule

// File: hdl/alu_exec.sv
// ######################################
// RV32I integer ALU with retire register
// ######################################
`timescale 1ns/1ps

module alu_exec (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rdy_in,
  exec_if.alu                exec,
  output logic               retire_valid,
  output cpu_pkg::reg_addr_t retire_rd,
  output cpu_pkg::word_t     retire_value
);

  logic [4:0]          sh;
  cpu_pkg::word_t      result;
  logic                ret_q;
  cpu_pkg::reg_addr_t  rd_q;
  cpu_pkg::word_t      value_q;

  assign sh = exec.rhs[4:0];

  always_comb begin
    case (exec.alu_op)
      cpu_pkg::ALU_ADD:  result = exec.lhs + exec.rhs;
      cpu_pkg::ALU_SUB:  result = exec.lhs - exec.rhs;
      cpu_pkg::ALU_SLL:  result = exec.lhs << sh;
      cpu_pkg::ALU_SLT:  result = cpu_pkg::word_t'($signed(exec.lhs) < $signed(exec.rhs));
      cpu_pkg::ALU_SLTU: result = cpu_pkg::word_t'(exec.lhs < exec.rhs);
      cpu_pkg::ALU_XOR:  result = exec.lhs ^ exec.rhs;
      cpu_pkg::ALU_SRL:  result = exec.lhs >> sh;
      cpu_pkg::ALU_SRA:  result = cpu_pkg::word_t'($signed(exec.lhs) >>> sh);
      cpu_pkg::ALU_OR:   result = exec.lhs | exec.rhs;
      cpu_pkg::ALU_AND:  result = exec.lhs & exec.rhs;
      // LUI immediate comes in on rhs
      cpu_pkg::ALU_PASS: result = exec.rhs;
      default:           result = '0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ret_q <= 1'b0;
    end else if (rdy_in) begin
      ret_q <= exec.issue_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && exec.issue_valid) begin
      value_q <= result;
      rd_q    <= exec.rd;
    end
  end

  assign retire_valid = ret_q && rdy_in;
  assign retire_rd    = rd_q;
  assign retire_value = value_q;

endmodule

// File: hdl/status_lamps.sv
// ######################################
// sticky activity lamps, cleared by reset
// ######################################
`timescale 1ns/1ps

module status_lamps (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,
  input  logic           fetch_start,
  input  logic           instr_valid,
  input  logic           issue_valid,
  input  logic           retire_valid,
  output cpu_pkg::lamp_t lamps
);

  cpu_pkg::lamp_t strobes;
  cpu_pkg::lamp_t lamps_q;

  // lamp 0 is fetch, lamp 3 is retire
  assign strobes = {retire_valid, issue_valid, instr_valid, fetch_start};

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      lamps_q <= '0;
    end else if (rdy_in) begin
      lamps_q <= lamps_q | strobes;
    end
  end

  assign lamps = lamps_q;

endmodule

// File: hdl/cpu.sv
// ######################################
// RV32I subset core top level
// ######################################
`timescale 1ns/1ps

module cpu (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rdy_in,
  input  cpu_pkg::byte_t     mem_din,
  output cpu_pkg::addr_t     mem_a,
  output logic               retire_valid,
  output cpu_pkg::reg_addr_t retire_rd,
  output cpu_pkg::word_t     dbgreg_dout,
  output cpu_pkg::lamp_t     lamps
);

  logic            instr_valid;
  cpu_pkg::instr_t instr;
  logic            fetch_start;

  exec_if exec_bus ();

  byte_fetcher u_fetch (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .rdy_in      (rdy_in),
    .mem_din     (mem_din),
    .mem_a       (mem_a),
    .instr_valid (instr_valid),
    .instr       (instr),
    .fetch_start (fetch_start)
  );

  decode_issue u_decode (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (dbgreg_dout),
    .exec         (exec_bus.decode)
  );

  // retired value doubles as the debug output
  alu_exec u_alu (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .exec         (exec_bus.alu),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_value (dbgreg_dout)
  );

  status_lamps u_lamps (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .fetch_start  (fetch_start),
    .instr_valid  (instr_valid),
    .issue_valid  (exec_bus.issue_valid),
    .retire_valid (retire_valid),
    .lamps        (lamps)
  );

endmodule

// File: dv/cpu_checker.sv
// ######################################
// protocol assertions bound to the core
// ######################################
`timescale 1ns/1ps

module cpu_checker (
  input logic           clk_in,
  input logic           rst_in,
  input logic           rdy_in,
  input cpu_pkg::addr_t mem_a,
  input logic           retire_valid,
  input cpu_pkg::lamp_t lamps
);

  // read by the testbench at the end of the run
  int violations = 0;

  // first cycle out of reset never retires
  retire_after_reset: assert property (@(posedge clk_in) rst_in |=> !retire_valid)
    else begin
      $error("retire_valid high in the cycle after reset");
      violations++;
    end

  // one instruction every five cycles at most
  retire_spacing: assert property (@(posedge clk_in) disable iff (rst_in)
      (retire_valid && rdy_in) |=> !retire_valid [*4])
    else begin
      $error("two retire pulses closer than five cycles");
      violations++;
    end

  lamps_sticky: assert property (@(posedge clk_in)
      !rst_in |=> (($past(lamps) & ~lamps) == '0))
    else begin
      $error("a status lamp fell without reset");
      violations++;
    end

  // paused fetch keeps its address on the bus
  addr_hold: assert property (@(posedge clk_in) (!rdy_in && !rst_in) |=> $stable(mem_a))
    else begin
      $error("mem_a changed across a cycle with rdy_in low");
      violations++;
    end

endmodule

// File: dv/tb_cpu.sv
// ######################################
// testbench running a random RV32I subset
// program against a reference model
// ######################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_cpu;

  localparam int          N_INSTR    = 200;
  localparam int          PROG_BYTES = N_INSTR * 4;
  localparam logic [31:0] SEED       = 32'h2a109994;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  logic               clk_in;
  logic               rst_in;
  logic               rdy_in;
  cpu_pkg::byte_t     mem_din;
  cpu_pkg::addr_t     mem_a;
  logic               retire_valid;
  cpu_pkg::reg_addr_t retire_rd;
  cpu_pkg::word_t     dbgreg_dout;
  cpu_pkg::lamp_t     lamps;

  logic [7:0]  prog_mem [PROG_BYTES];
  logic [4:0]  exp_rd [N_INSTR];
  logic [31:0] exp_val [N_INSTR];
  logic [31:0] model_regs [32];
  logic [31:0] lfsr_q;
  logic [31:0] addr_q;
  int          n_sup;
  int          ret_idx;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          pause_left;
  int          pause_count;
  int          x0_errors;
  bit          pause_mode;
  bit          monitor_on;
  bit          x0_seen;

  cpu u_cpu (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .mem_din      (mem_din),
    .mem_a        (mem_a),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .dbgreg_dout  (dbgreg_dout),
    .lamps        (lamps)
  );

  bind cpu cpu_checker u_checker (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .mem_a        (mem_a),
    .retire_valid (retire_valid),
    .lamps        (lamps)
  );

  always #50 clk_in = ~clk_in;

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic bit is_kept(input logic [6:0] opc);
    return opc == `CPU_OPC_OP || opc == `CPU_OPC_OP_IMM || opc == `CPU_OPC_LUI;
  endfunction

  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    if (a < PROG_BYTES) begin
      return prog_mem[a];
    end
    // custom-0 words past the program never retire
    if (a[1:0] == 2'b00) begin
      return 8'h0b;
    end
    return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
  endfunction

  // RV32I result from the instruction fields and the model registers
  function automatic logic [31:0] model_result(input logic [31:0] ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic        is_op;
    is_op = ins[6:0] == `CPU_OPC_OP;
    a = model_regs[ins[19:15]];
    b = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    r = '0;
    case (ins[14:12])
      3'd0: begin
        if (is_op && ins[30]) begin
          r = a - b;
        end else begin
          r = a + b;
        end
      end
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (ins[30]) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (ins[6:0] == `CPU_OPC_LUI) begin
      r = {ins[31:12], 12'h000};
    end
    return r;
  endfunction

  task automatic build_program();
    logic [31:0] ins;
    logic [31:0] up;
    logic [31:0] val;
    logic [4:0]  sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [6:0]  opc;
    n_sup = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int i = 0; i < N_INSTR; i++) begin
      sel = rand_bits(5);
      rd  = rand_bits(5);
      rs1 = rand_bits(5);
      rs2 = rand_bits(5);
      f3  = rand_bits(3);
      alt = rand_bits(1);
      imm = rand_bits(12);
      if (sel < 3) begin
        up  = rand_bits(25);
        opc = rand_bits(7);
        if (is_kept(opc)) begin
          opc = opc ^ 7'h01;
        end
        ins = {up[24:0], opc};
      end else if (sel < 16) begin
        // funct7 alt bit only exists for SUB and SRA
        if (f3 != 3'd0 && f3 != 3'd5) begin
          alt = 1'b0;
        end
        ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `CPU_OPC_OP};
      end else if (sel < 29) begin
        if (f3 == 3'd1) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == 3'd5) begin
          imm = {1'b0, alt, 5'b0, imm[4:0]};
        end
        ins = {imm, rs1, f3, rd, `CPU_OPC_OP_IMM};
      end else begin
        up  = rand_bits(20);
        ins = {up[19:0], rd, `CPU_OPC_LUI};
      end
      // addi to x0 then an add reading x0 twice
      if (i == 3) begin
        ins = {imm, rs1, 3'b000, 5'd0, `CPU_OPC_OP_IMM};
      end else if (i == 4) begin
        ins = {7'b0, 5'd0, 5'd0, 3'b000, rd, `CPU_OPC_OP};
      end
      for (int b = 0; b < 4; b++) begin
        prog_mem[4 * i + b] = ins[8 * b +: 8];
      end
      if (is_kept(ins[6:0])) begin
        val = model_result(ins);
        exp_rd[n_sup]  = ins[11:7];
        exp_val[n_sup] = val;
        if (ins[11:7] != 5'd0) begin
          model_regs[ins[11:7]] = val;
        end
        n_sup++;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name, input bit ok);
    if (ok) begin
      $display("test %0d %s: ok", num, name);
      tests_passed++;
    end else begin
      $display("test %0d %s: failed", num, name);
      tests_failed++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_in);
    #1;
    rst_in = 1'b1;
    repeat (2) @(posedge clk_in);
    #1;
    rst_in  = 1'b0;
    ret_idx = 0;
  endtask

  task automatic wait_retires(input int limit, input string what);
    int cyc;
    cyc = 0;
    while (ret_idx < n_sup && cyc < limit) begin
      @(negedge clk_in);
      cyc++;
    end
    assert (ret_idx >= n_sup) else begin
      $display("timeout after %0d cycles waiting for %s, %0d of %0d retires seen",
               cyc, what, ret_idx, n_sup);
      errors++;
    end
  endtask

  // memory answers the address of the previous cycle
  always @(negedge clk_in) begin
    addr_q = mem_a;
  end

  always @(posedge clk_in) begin
    #1;
    mem_din = mem_byte(addr_q);
  end

  // rdy_in drops for 1 to 3 cycles at random
  always @(posedge clk_in) begin
    #1;
    if (!pause_mode) begin
      rdy_in = 1'b1;
    end else if (pause_left > 0) begin
      rdy_in = 1'b0;
      pause_left--;
      pause_count++;
    end else if (rand_bits(3) == 0) begin
      rdy_in = 1'b0;
      pause_left = rand_bits(2) % 3;
      pause_count++;
    end else begin
      rdy_in = 1'b1;
    end
  end

  always @(negedge clk_in) begin
    if (monitor_on && !rst_in && retire_valid) begin
      assert (ret_idx < n_sup) else begin
        $display("unexpected retire at t=%0t after the last instruction", $time);
        errors++;
      end
      if (ret_idx < n_sup) begin
        if (exp_rd[ret_idx] == 5'd0 && !x0_seen) begin
          x0_seen   = 1'b1;
          x0_errors = errors;
        end
        check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[ret_idx]));
        check_value("dbgreg_dout", dbgreg_dout, exp_val[ret_idx]);
        ret_idx++;
      end
    end
  end

  initial begin
    int  err0;
    bit  lamps_ok;
    clk_in       = 1'b0;
    rst_in       = 1'b1;
    rdy_in       = 1'b1;
    mem_din      = '0;
    addr_q       = '0;
    lfsr_q       = SEED;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    pause_mode   = 1'b0;
    pause_left   = 0;
    pause_count  = 0;
    monitor_on   = 1'b0;
    x0_seen      = 1'b0;
    x0_errors    = 0;
    ret_idx      = 0;
    build_program();
    $display("program of %0d instructions, %0d expected retires", N_INSTR, n_sup);

    // first run with rdy_in high
    apply_reset();
    monitor_on = 1'b1;
    err0 = errors;
    @(negedge clk_in);
    check_value("mem_a", mem_a, 32'd0);
    check_value("retire_valid", 32'(retire_valid), 32'd0);
    check_value("lamps", 32'(lamps), 32'd0);
    for (int k = 1; k < 4; k++) begin
      @(negedge clk_in);
      check_value("mem_a", mem_a, 32'(k));
    end
    report_test(1, "reset state and first fetch", errors == err0);

    err0 = errors;
    wait_retires(N_INSTR * 5 + 100, "retires with rdy_in high");
    repeat (20) @(negedge clk_in);
    report_test(2, "retire values with rdy_in high", errors == err0);
    report_test(3, "x0 write and read", x0_seen && errors == x0_errors);

    err0 = errors;
    check_value("lamps", 32'(lamps), 32'hf);
    lamps_ok = errors == err0;

    // second run with pauses after a second reset
    apply_reset();
    err0 = errors;
    @(negedge clk_in);
    check_value("lamps", 32'(lamps), 32'd0);
    check_value("mem_a", mem_a, 32'd0);
    @(negedge clk_in);
    check_value("mem_a", mem_a, 32'd1);
    lamps_ok = lamps_ok && errors == err0;

    err0 = errors;
    pause_mode = 1'b1;
    wait_retires(N_INSTR * 20, "retires with rdy_in pauses");
    pause_mode = 1'b0;
    repeat (20) @(negedge clk_in);
    report_test(4, "pause tolerance", errors == err0 && pause_count > 0);

    err0 = errors;
    check_value("lamps", 32'(lamps), 32'hf);
    report_test(5, "sticky lamps and second reset", lamps_ok && errors == err0);

    assert (u_cpu.u_checker.violations == 0) else begin
      $display("bound checker reported %0d assertion failures",
               u_cpu.u_checker.violations);
      errors++;
    end

    $display("tests passed %0d failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/exec_if.sv
hdl/byte_fetcher.sv
hdl/decode_issue.sv
hdl/alu_exec.sv
hdl/status_lamps.sv
hdl/cpu.sv
dv/cpu_checker.sv
dv/tb_cpu.sv

// File: Bender.yml
package:
  name: rv32i_byte_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/exec_if.sv
      - hdl/byte_fetcher.sv
      - hdl/decode_issue.sv
      - hdl/alu_exec.sv
      - hdl/status_lamps.sv
      - hdl/cpu.sv
      - target: simulation
        files:
          - dv/cpu_checker.sv
          - dv/tb_cpu.sv
